// File: Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/isaPkg.sv
      - hw/pipePkg.sv
      - hw/fetchStage.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/memoryStage.sv
      - hw/regFile.sv
      - hw/hazardUnit.sv
      - hw/cpuCore.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/cpuCoreTb.sv

// File: hw/cpuCore.sv
// Five-stage MIPS32 subset core
// Connects the stages, register file and hazard unit, and reports status PC
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire logic         clk,
    input  wire logic         rstN,
    output isaPkg::wordT      IAddr,
    input  wire isaPkg::wordT IData,
    output isaPkg::wordT      DAddr,
    output logic              DWEn,
    output logic              DREn,
    output logic [3:0]        DByteEn,
    output isaPkg::wordT      DWData,
    input  wire isaPkg::wordT DRData,
    output isaPkg::wordT      PC
);

    isaPkg::wordT    code_D, PC_D, dataRs_D, dataRt_D, branchTarget;
    isaPkg::regAddrT addrRs_D, addrRt_D;
    pipePkg::timeT   TuseRs_D, TuseRt_D;
    logic            useRs_D, useRt_D, branchTaken;

    isaPkg::aluOpT   aluOp_E;
    isaPkg::resSrcT  resSrc_E;
    isaPkg::wordT    imm_E, dataRs_E, dataRt_E, link_E, PC_E;
    isaPkg::shamtT   shamt_E;
    isaPkg::regAddrT addrRs_E, addrRt_E, regWAddr_E;
    pipePkg::timeT   Tnew_E;
    logic            aluSrcImm_E, memWEn_E, useRs_E, useRt_E, regWEn_E;

    isaPkg::wordT    aluOut_M, dataRt_M, PC_M;
    isaPkg::resSrcT  resSrc_M;
    isaPkg::regAddrT addrRt_M, regWAddr_M;
    pipePkg::timeT   Tnew_M;
    logic            memWEn_M, useRt_M, regWEn_M;

    isaPkg::wordT    regWData;
    isaPkg::regAddrT regWAddr;
    logic            regWEn;

    logic            stall;
    pipePkg::fwdSelT fwdRsD, fwdRtD, fwdRsE, fwdRtE;

    fetchStage fetch_inst (
        .clk(clk), .rstN(rstN), .stall(stall),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .IAddr(IAddr), .IData(IData), .code_D(code_D), .PC_D(PC_D)
    );

    decodeStage decode_inst (
        .clk(clk), .rstN(rstN), .stall(stall), .code_D(code_D), .PC_D(PC_D),
        .addrRs_D(addrRs_D), .addrRt_D(addrRt_D), .dataRs_D(dataRs_D), .dataRt_D(dataRt_D),
        .fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .aluOut_M(aluOut_M), .regWData(regWData),
        .useRs_D(useRs_D), .useRt_D(useRt_D), .TuseRs_D(TuseRs_D), .TuseRt_D(TuseRt_D),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .aluOp_E(aluOp_E), .aluSrcImm_E(aluSrcImm_E), .resSrc_E(resSrc_E),
        .memWEn_E(memWEn_E), .imm_E(imm_E), .shamt_E(shamt_E),
        .dataRs_E(dataRs_E), .dataRt_E(dataRt_E), .addrRs_E(addrRs_E), .addrRt_E(addrRt_E),
        .useRs_E(useRs_E), .useRt_E(useRt_E), .regWEn_E(regWEn_E),
        .regWAddr_E(regWAddr_E), .Tnew_E(Tnew_E), .link_E(link_E)
    );

    executeStage execute_inst (
        .clk(clk), .rstN(rstN),
        .aluOp_E(aluOp_E), .aluSrcImm_E(aluSrcImm_E), .resSrc_E(resSrc_E),
        .memWEn_E(memWEn_E), .imm_E(imm_E), .shamt_E(shamt_E),
        .dataRs_E(dataRs_E), .dataRt_E(dataRt_E), .addrRt_E(addrRt_E), .useRt_E(useRt_E),
        .regWEn_E(regWEn_E), .regWAddr_E(regWAddr_E), .Tnew_E(Tnew_E), .link_E(link_E),
        .fwdRsE(fwdRsE), .fwdRtE(fwdRtE), .regWData(regWData),
        .aluOut_M(aluOut_M), .dataRt_M(dataRt_M), .memWEn_M(memWEn_M), .resSrc_M(resSrc_M),
        .addrRt_M(addrRt_M), .useRt_M(useRt_M), .regWEn_M(regWEn_M),
        .regWAddr_M(regWAddr_M), .Tnew_M(Tnew_M)
    );

    memoryStage memory_inst (
        .clk(clk), .rstN(rstN),
        .aluOut_M(aluOut_M), .dataRt_M(dataRt_M), .memWEn_M(memWEn_M), .resSrc_M(resSrc_M),
        .addrRt_M(addrRt_M), .useRt_M(useRt_M), .regWEn_M(regWEn_M),
        .regWAddr_M(regWAddr_M), .Tnew_M(Tnew_M),
        .DAddr(DAddr), .DWEn(DWEn), .DREn(DREn), .DByteEn(DByteEn),
        .DWData(DWData), .DRData(DRData),
        .regWEn(regWEn), .regWAddr(regWAddr), .regWData(regWData), .Tnew_W()
    );

    regFile regFile_inst (
        .clk(clk), .rstN(rstN),
        .RAddr1(addrRs_D), .RAddr2(addrRt_D), .RData1(dataRs_D), .RData2(dataRt_D),
        .WEn(regWEn), .WAddr(regWAddr), .WData(regWData)
    );

    hazardUnit hazard_inst (
        .useRs_D(useRs_D), .useRt_D(useRt_D), .addrRs_D(addrRs_D), .addrRt_D(addrRt_D),
        .TuseRs_D(TuseRs_D), .TuseRt_D(TuseRt_D),
        .useRs_E(useRs_E), .useRt_E(useRt_E), .addrRs_E(addrRs_E), .addrRt_E(addrRt_E),
        .regWEn_E(regWEn_E), .regWAddr_E(regWAddr_E), .Tnew_E(Tnew_E),
        .regWEn_M(regWEn_M), .regWAddr_M(regWAddr_M), .Tnew_M(Tnew_M),
        .regWEn(regWEn), .regWAddr(regWAddr),
        .stall(stall), .fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .fwdRsE(fwdRsE), .fwdRtE(fwdRtE)
    );

    // Zero PC marks a bubble
    always_ff @(posedge clk) begin
        if (!rstN) begin
            PC_E <= '0;
            PC_M <= '0;
        end else begin
            PC_E <= stall ? '0 : PC_D;
            PC_M <= PC_E;
        end
    end

    assign PC = (PC_M != '0) ? PC_M : IAddr;

endmodule

`default_nettype wire

// File: hw/cpu_defs.svh
// CPU core configuration
// Word width, general register count and the first fetch address
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data and address width
`define CPU_WORD 32

// General register count
`define CPU_NREG 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_3000

`endif

// File: hw/decodeStage.sv
// Decode stage
// Decodes control, resolves branches and jumps with forwarded operands,
// and loads the decode/execute register
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire logic            stall,
    input  wire isaPkg::wordT    code_D,
    input  wire isaPkg::wordT    PC_D,
    output isaPkg::regAddrT      addrRs_D,
    output isaPkg::regAddrT      addrRt_D,
    input  wire isaPkg::wordT    dataRs_D,
    input  wire isaPkg::wordT    dataRt_D,
    input  wire pipePkg::fwdSelT fwdRsD,
    input  wire pipePkg::fwdSelT fwdRtD,
    input  wire isaPkg::wordT    aluOut_M,
    input  wire isaPkg::wordT    regWData,
    output logic                 useRs_D,
    output logic                 useRt_D,
    output pipePkg::timeT        TuseRs_D,
    output pipePkg::timeT        TuseRt_D,
    output logic                 branchTaken,
    output isaPkg::wordT         branchTarget,
    output isaPkg::aluOpT        aluOp_E,
    output logic                 aluSrcImm_E,
    output isaPkg::resSrcT       resSrc_E,
    output logic                 memWEn_E,
    output isaPkg::wordT         imm_E,
    output isaPkg::shamtT        shamt_E,
    output isaPkg::wordT         dataRs_E,
    output isaPkg::wordT         dataRt_E,
    output isaPkg::regAddrT      addrRs_E,
    output isaPkg::regAddrT      addrRt_E,
    output logic                 useRs_E,
    output logic                 useRt_E,
    output logic                 regWEn_E,
    output isaPkg::regAddrT      regWAddr_E,
    output pipePkg::timeT        Tnew_E,
    output isaPkg::wordT         link_E
);

    isaPkg::opcodeT          opcode;
    isaPkg::functT           funct;
    logic [isaPkg::IMM_W-1:0] immField;
    isaPkg::wordT            immSext;
    isaPkg::wordT            immExt;
    isaPkg::wordT            pcPlus4;
    isaPkg::wordT            rsVal;
    isaPkg::wordT            rtVal;
    isaPkg::aluOpT           aluOp;
    isaPkg::resSrcT          resSrc;
    isaPkg::regAddrT         regWAddr;
    pipePkg::timeT           Tnew;
    logic                    aluSrcImm;
    logic                    memWEn;
    logic                    regWEn;
    logic                    immSigned;
    logic                    isBeq;
    logic                    isBne;
    logic                    isJump;
    logic                    isJr;

    assign opcode   = isaPkg::opcodeT'(code_D[31:26]);
    assign funct    = isaPkg::functT'(code_D[5:0]);
    assign addrRs_D = code_D[25:21];
    assign addrRt_D = code_D[20:16];
    assign immField = code_D[15:0];
    assign immSext  = isaPkg::wordT'(signed'(immField));
    assign immExt   = immSigned ? immSext : isaPkg::wordT'(immField);
    assign pcPlus4  = PC_D + 32'd4;

    always_comb begin
        aluOp     = isaPkg::ALU_PASS;
        aluSrcImm = 1'b0;
        resSrc    = isaPkg::RES_ALU;
        memWEn    = 1'b0;
        regWEn    = 1'b0;
        regWAddr  = code_D[15:11];
        Tnew      = pipePkg::TNEW_ALU;
        useRs_D   = 1'b0;
        useRt_D   = 1'b0;
        TuseRs_D  = pipePkg::TUSE_ALU;
        TuseRt_D  = pipePkg::TUSE_ALU;
        immSigned = 1'b1;
        isBeq     = 1'b0;
        isBne     = 1'b0;
        isJump    = 1'b0;
        isJr      = 1'b0;
        case (opcode)
            isaPkg::OP_SPECIAL: begin
                useRs_D = 1'b1;
                useRt_D = 1'b1;
                regWEn  = 1'b1;
                case (funct)
                    isaPkg::FN_ADDU: aluOp = isaPkg::ALU_ADD;
                    isaPkg::FN_SUBU: aluOp = isaPkg::ALU_SUB;
                    isaPkg::FN_AND:  aluOp = isaPkg::ALU_AND;
                    isaPkg::FN_OR:   aluOp = isaPkg::ALU_OR;
                    isaPkg::FN_SLT:  aluOp = isaPkg::ALU_SLT;
                    isaPkg::FN_SLL: begin
                        aluOp   = isaPkg::ALU_SLL;
                        useRs_D = 1'b0;
                    end
                    isaPkg::FN_JR: begin
                        regWEn   = 1'b0;
                        useRt_D  = 1'b0;
                        isJr     = 1'b1;
                        TuseRs_D = pipePkg::TUSE_BRANCH;
                    end
                    default: begin
                        regWEn  = 1'b0;
                        useRs_D = 1'b0;
                        useRt_D = 1'b0;
                    end
                endcase
            end
            isaPkg::OP_ADDIU, isaPkg::OP_ORI, isaPkg::OP_LUI, isaPkg::OP_LW: begin
                aluSrcImm = 1'b1;
                regWEn    = 1'b1;
                regWAddr  = addrRt_D;
                useRs_D   = (opcode != isaPkg::OP_LUI);
                immSigned = (opcode == isaPkg::OP_ADDIU) || (opcode == isaPkg::OP_LW);
                if (opcode == isaPkg::OP_ORI) begin
                    aluOp = isaPkg::ALU_OR;
                end else if (opcode == isaPkg::OP_LUI) begin
                    aluOp = isaPkg::ALU_LUI;
                end else begin
                    aluOp = isaPkg::ALU_ADD;
                end
                if (opcode == isaPkg::OP_LW) begin
                    resSrc = isaPkg::RES_MEM;
                    Tnew   = pipePkg::TNEW_LOAD;
                end
            end
            isaPkg::OP_SW: begin
                aluOp     = isaPkg::ALU_ADD;
                aluSrcImm = 1'b1;
                memWEn    = 1'b1;
                useRs_D   = 1'b1;
                useRt_D   = 1'b1;
                TuseRt_D  = pipePkg::TUSE_STORE;
            end
            isaPkg::OP_BEQ, isaPkg::OP_BNE: begin
                useRs_D  = 1'b1;
                useRt_D  = 1'b1;
                TuseRs_D = pipePkg::TUSE_BRANCH;
                TuseRt_D = pipePkg::TUSE_BRANCH;
                isBeq    = (opcode == isaPkg::OP_BEQ);
                isBne    = (opcode == isaPkg::OP_BNE);
            end
            isaPkg::OP_J: isJump = 1'b1;
            isaPkg::OP_JAL: begin
                isJump   = 1'b1;
                regWEn   = 1'b1;
                regWAddr = 5'd31;
                resSrc   = isaPkg::RES_LINK;
                Tnew     = pipePkg::TNEW_LINK;
            end
            default: ;
        endcase
    end

    // Operands as seen by the branch compare and the D/E register
    assign rsVal = (fwdRsD == pipePkg::FWD_M) ? aluOut_M :
                   (fwdRsD == pipePkg::FWD_W) ? regWData : dataRs_D;
    assign rtVal = (fwdRtD == pipePkg::FWD_M) ? aluOut_M :
                   (fwdRtD == pipePkg::FWD_W) ? regWData : dataRt_D;

    assign branchTaken = isJump || isJr || (isBeq && (rsVal == rtVal)) ||
                         (isBne && (rsVal != rtVal));

    always_comb begin
        if (isJr) begin
            branchTarget = rsVal;
        end else if (isJump) begin
            branchTarget = {pcPlus4[31:28], code_D[25:0], 2'b00};
        end else begin
            branchTarget = pcPlus4 + (immSext << 2);
        end
    end

    // Stall leaves a bubble behind
    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            aluOp_E     <= isaPkg::ALU_PASS;
            aluSrcImm_E <= 1'b0;
            resSrc_E    <= isaPkg::RES_ALU;
            memWEn_E    <= 1'b0;
            regWEn_E    <= 1'b0;
            regWAddr_E  <= '0;
            Tnew_E      <= '0;
            useRs_E     <= 1'b0;
            useRt_E     <= 1'b0;
            addrRs_E    <= '0;
            addrRt_E    <= '0;
        end else begin
            aluOp_E     <= aluOp;
            aluSrcImm_E <= aluSrcImm;
            resSrc_E    <= resSrc;
            memWEn_E    <= memWEn;
            regWEn_E    <= regWEn;
            regWAddr_E  <= regWAddr;
            Tnew_E      <= Tnew;
            useRs_E     <= useRs_D;
            useRt_E     <= useRt_D;
            addrRs_E    <= addrRs_D;
            addrRt_E    <= addrRt_D;
        end
        imm_E    <= immExt;
        shamt_E  <= code_D[10:6];
        dataRs_E <= rsVal;
        dataRt_E <= rtVal;
        link_E   <= PC_D + 32'd8;
    end

endmodule

`default_nettype wire

// File: hw/executeStage.sv
// Execute stage
// ALU on forwarded operands and the execute/memory register
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire isaPkg::aluOpT   aluOp_E,
    input  wire logic            aluSrcImm_E,
    input  wire isaPkg::resSrcT  resSrc_E,
    input  wire logic            memWEn_E,
    input  wire isaPkg::wordT    imm_E,
    input  wire isaPkg::shamtT   shamt_E,
    input  wire isaPkg::wordT    dataRs_E,
    input  wire isaPkg::wordT    dataRt_E,
    input  wire isaPkg::regAddrT addrRt_E,
    input  wire logic            useRt_E,
    input  wire logic            regWEn_E,
    input  wire isaPkg::regAddrT regWAddr_E,
    input  wire pipePkg::timeT   Tnew_E,
    input  wire isaPkg::wordT    link_E,
    input  wire pipePkg::fwdSelT fwdRsE,
    input  wire pipePkg::fwdSelT fwdRtE,
    input  wire isaPkg::wordT    regWData,
    output isaPkg::wordT         aluOut_M,
    output isaPkg::wordT         dataRt_M,
    output logic                 memWEn_M,
    output isaPkg::resSrcT       resSrc_M,
    output isaPkg::regAddrT      addrRt_M,
    output logic                 useRt_M,
    output logic                 regWEn_M,
    output isaPkg::regAddrT      regWAddr_M,
    output pipePkg::timeT        Tnew_M
);

    isaPkg::wordT srcA;
    isaPkg::wordT rtVal;
    isaPkg::wordT srcB;
    isaPkg::wordT aluRes;

    assign srcA  = (fwdRsE == pipePkg::FWD_M) ? aluOut_M :
                   (fwdRsE == pipePkg::FWD_W) ? regWData : dataRs_E;
    assign rtVal = (fwdRtE == pipePkg::FWD_M) ? aluOut_M :
                   (fwdRtE == pipePkg::FWD_W) ? regWData : dataRt_E;
    assign srcB  = aluSrcImm_E ? imm_E : rtVal;

    always_comb begin
        case (aluOp_E)
            isaPkg::ALU_ADD: aluRes = srcA + srcB;
            isaPkg::ALU_SUB: aluRes = srcA - srcB;
            isaPkg::ALU_AND: aluRes = srcA & srcB;
            isaPkg::ALU_OR:  aluRes = srcA | srcB;
            isaPkg::ALU_SLT: aluRes = isaPkg::wordT'($signed(srcA) < $signed(srcB));
            isaPkg::ALU_SLL: aluRes = srcB << shamt_E;
            isaPkg::ALU_LUI: aluRes = {srcB[15:0], 16'h0000};
            default:         aluRes = srcB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWEn_M   <= 1'b0;
            resSrc_M   <= isaPkg::RES_ALU;
            addrRt_M   <= '0;
            useRt_M    <= 1'b0;
            regWEn_M   <= 1'b0;
            regWAddr_M <= '0;
            Tnew_M     <= '0;
        end else begin
            memWEn_M   <= memWEn_E;
            resSrc_M   <= resSrc_E;
            addrRt_M   <= addrRt_E;
            useRt_M    <= useRt_E;
            regWEn_M   <= regWEn_E;
            regWAddr_M <= regWAddr_E;
            Tnew_M     <= (Tnew_E == '0) ? '0 : Tnew_E - 2'd1;
        end
        // Link address rides in the ALU result slot
        aluOut_M <= (resSrc_E == isaPkg::RES_LINK) ? link_E : aluRes;
        dataRt_M <= rtVal;
    end

endmodule

`default_nettype wire

// File: hw/fetchStage.sv
// Fetch stage
// Program counter, next-PC choice and the fetch/decode register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module fetchStage (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic         stall,
    input  wire logic         branchTaken,
    input  wire isaPkg::wordT branchTarget,
    output isaPkg::wordT      IAddr,
    input  wire isaPkg::wordT IData,
    output isaPkg::wordT      code_D,
    output isaPkg::wordT      PC_D
);

    // IAddr is the PC register itself
    always_ff @(posedge clk) begin
        if (!rstN) begin
            IAddr  <= `CPU_RESET_PC;
            code_D <= '0;
            PC_D   <= '0;
        end else if (!stall) begin
            IAddr  <= branchTaken ? branchTarget : IAddr + 32'd4;
            code_D <= IData;
            PC_D   <= IAddr;
        end
    end

endmodule

`default_nettype wire

// File: hw/hazardUnit.sv
// Hazard unit
// Compares operand Tuse with pending write Tnew to pick forwarding or stall
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire logic            useRs_D,
    input  wire logic            useRt_D,
    input  wire isaPkg::regAddrT addrRs_D,
    input  wire isaPkg::regAddrT addrRt_D,
    input  wire pipePkg::timeT   TuseRs_D,
    input  wire pipePkg::timeT   TuseRt_D,
    input  wire logic            useRs_E,
    input  wire logic            useRt_E,
    input  wire isaPkg::regAddrT addrRs_E,
    input  wire isaPkg::regAddrT addrRt_E,
    input  wire logic            regWEn_E,
    input  wire isaPkg::regAddrT regWAddr_E,
    input  wire pipePkg::timeT   Tnew_E,
    input  wire logic            regWEn_M,
    input  wire isaPkg::regAddrT regWAddr_M,
    input  wire pipePkg::timeT   Tnew_M,
    input  wire logic            regWEn,
    input  wire isaPkg::regAddrT regWAddr,
    output logic                 stall,
    output pipePkg::fwdSelT      fwdRsD,
    output pipePkg::fwdSelT      fwdRtD,
    output pipePkg::fwdSelT      fwdRsE,
    output pipePkg::fwdSelT      fwdRtE
);

    // Newest matching writer wins, even when its value is not ready yet
    function automatic pipePkg::fwdSelT pickSrc(input logic used,
                                                input isaPkg::regAddrT addr);
        logic hitM;
        logic hitW;
        hitM = used && regWEn_M && (regWAddr_M == addr) && (addr != '0);
        hitW = used && regWEn && (regWAddr == addr) && (addr != '0);
        if (hitM) begin
            pickSrc = (Tnew_M == '0) ? pipePkg::FWD_M : pipePkg::FWD_RF;
        end else if (hitW) begin
            pickSrc = pipePkg::FWD_W;
        end else begin
            pickSrc = pipePkg::FWD_RF;
        end
    endfunction

    function automatic logic mustWait(input logic used, input isaPkg::regAddrT addr,
                                      input pipePkg::timeT tuse);
        logic hitE;
        logic hitM;
        hitE = used && regWEn_E && (regWAddr_E == addr) && (addr != '0);
        hitM = used && regWEn_M && (regWAddr_M == addr) && (addr != '0);
        mustWait = (hitE && (Tnew_E > tuse)) || (hitM && (Tnew_M > tuse));
    endfunction

    always_comb begin
        stall  = mustWait(useRs_D, addrRs_D, TuseRs_D) ||
                 mustWait(useRt_D, addrRt_D, TuseRt_D);
        fwdRsD = pickSrc(useRs_D, addrRs_D);
        fwdRtD = pickSrc(useRt_D, addrRt_D);
        fwdRsE = pickSrc(useRs_E, addrRs_E);
        fwdRtE = pickSrc(useRt_E, addrRt_E);
    end

endmodule

`default_nettype wire

// File: hw/isaPkg.sv
// MIPS32 subset definitions
// Field widths, opcode and function encodings, ALU operations
`default_nettype none
`include "cpu_defs.svh"

package isaPkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int REG_W    = 5;
    localparam int SHAMT_W  = 5;
    localparam int IMM_W    = 16;

    typedef logic [`CPU_WORD-1:0] wordT;
    typedef logic [REG_W-1:0]     regAddrT;
    typedef logic [SHAMT_W-1:0]   shamtT;

    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeT;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'h00,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI,
        ALU_PASS
    } aluOpT;

    // Where the written register value comes from
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_LINK
    } resSrcT;

endpackage

`default_nettype wire

// File: hw/memoryStage.sv
// Memory stage
// Drives the data port, registers the result and presents the register write
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire isaPkg::wordT    aluOut_M,
    input  wire isaPkg::wordT    dataRt_M,
    input  wire logic            memWEn_M,
    input  wire isaPkg::resSrcT  resSrc_M,
    input  wire isaPkg::regAddrT addrRt_M,
    input  wire logic            useRt_M,
    input  wire logic            regWEn_M,
    input  wire isaPkg::regAddrT regWAddr_M,
    input  wire pipePkg::timeT   Tnew_M,
    output isaPkg::wordT         DAddr,
    output logic                 DWEn,
    output logic                 DREn,
    output logic [3:0]           DByteEn,
    output isaPkg::wordT         DWData,
    input  wire isaPkg::wordT    DRData,
    output logic                 regWEn,
    output isaPkg::regAddrT      regWAddr,
    output isaPkg::wordT         regWData,
    output pipePkg::timeT        Tnew_W
);

    isaPkg::resSrcT resSrc_W;
    isaPkg::wordT   aluOut_W;
    isaPkg::wordT   memWord_W;
    logic           storeFwd;

    // Store data from a load that was one cycle ahead
    assign storeFwd = useRt_M && regWEn && (Tnew_W == '0) &&
                      (regWAddr == addrRt_M) && (addrRt_M != '0);

    assign DAddr   = aluOut_M;
    assign DWEn    = memWEn_M;
    assign DREn    = (resSrc_M == isaPkg::RES_MEM);
    assign DByteEn = memWEn_M ? 4'hf : 4'h0;
    assign DWData  = storeFwd ? regWData : dataRt_M;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWEn   <= 1'b0;
            regWAddr <= '0;
            resSrc_W <= isaPkg::RES_ALU;
            Tnew_W   <= '0;
        end else begin
            regWEn   <= regWEn_M;
            regWAddr <= regWAddr_M;
            resSrc_W <= resSrc_M;
            Tnew_W   <= (Tnew_M == '0) ? '0 : Tnew_M - 2'd1;
        end
        aluOut_W  <= aluOut_M;
        memWord_W <= DRData;
    end

    assign regWData = (resSrc_W == isaPkg::RES_MEM) ? memWord_W : aluOut_W;

endmodule

`default_nettype wire

// File: hw/pipePkg.sv
// Pipeline control definitions
// Operand timing counts and forwarding selects
`default_nettype none

package pipePkg;

    // Cycles until an operand is needed or a result exists
    typedef logic [1:0] timeT;

    localparam timeT TUSE_BRANCH = 2'd0;
    localparam timeT TUSE_ALU    = 2'd1;
    localparam timeT TUSE_STORE  = 2'd2;

    // Counted from execute
    localparam timeT TNEW_LINK = 2'd0;
    localparam timeT TNEW_ALU  = 2'd1;
    localparam timeT TNEW_LOAD = 2'd2;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_M,
        FWD_W
    } fwdSelT;

endpackage

`default_nettype wire

// File: hw/regFile.sv
// General register file
// Two read ports and one write port with write-through to same-cycle reads
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module regFile (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire isaPkg::regAddrT RAddr1,
    input  wire isaPkg::regAddrT RAddr2,
    output isaPkg::wordT         RData1,
    output isaPkg::wordT         RData2,
    input  wire logic            WEn,
    input  wire isaPkg::regAddrT WAddr,
    input  wire isaPkg::wordT    WData
);

    isaPkg::wordT regs [`CPU_NREG];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (WEn && (WAddr != '0)) begin
            regs[WAddr] <= WData;
        end
    end

    assign RData1 = (RAddr1 == '0) ? '0 :
                    (WEn && (WAddr == RAddr1)) ? WData : regs[RAddr1];
    assign RData2 = (RAddr2 == '0) ? '0 :
                    (WEn && (WAddr == RAddr2)) ? WData : regs[RAddr2];

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/isaPkg.sv
hw/pipePkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/cpuCore.sv
sim/cpuCoreTb.sv

// File: sim/cpuCoreTb.sv
// Testbench for the five-stage MIPS32 subset core
// Runs the program from the testdata file, checks each store in order and the final PC
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpuCoreTb;

    localparam int TDATA_WORDS   = 256;
    localparam int MEM_WORDS     = 256;
    localparam int SETTLE_CYCLES = 8;

    logic         clk;
    logic         rstN;
    isaPkg::wordT IAddr;
    isaPkg::wordT IData;
    isaPkg::wordT DAddr;
    logic         DWEn;
    logic         DREn;
    logic [3:0]   DByteEn;
    isaPkg::wordT DWData;
    isaPkg::wordT DRData;
    isaPkg::wordT PC;

    isaPkg::wordT tdata [TDATA_WORDS];
    isaPkg::wordT imem [MEM_WORDS];
    isaPkg::wordT dmem [MEM_WORDS];
    isaPkg::wordT expAddr [$];
    isaPkg::wordT expData [$];
    isaPkg::wordT finalPc;
    isaPkg::wordT fetchIdx;
    int           progLen;
    int           storeIdx;
    int           valueErrs;
    int           otherErrs;

    cpuCore cpuCore_inst (
        .clk(clk), .rstN(rstN),
        .IAddr(IAddr), .IData(IData),
        .DAddr(DAddr), .DWEn(DWEn), .DREn(DREn), .DByteEn(DByteEn),
        .DWData(DWData), .DRData(DRData),
        .PC(PC)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign fetchIdx = (IAddr - `CPU_RESET_PC) >> 2;
    assign IData    = (fetchIdx < MEM_WORDS) ? imem[fetchIdx[7:0]] : '0;
    // Data memory only answers the read strobe
    assign DRData   = DREn ? dmem[DAddr[9:2]] : '0;

    function automatic isaPkg::wordT mergeBytes(input isaPkg::wordT old,
                                                input isaPkg::wordT data,
                                                input logic [3:0] byteEn);
        isaPkg::wordT merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (byteEn[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    always @(posedge clk) begin
        if (DWEn) begin
            dmem[DAddr[9:2]] <= mergeBytes(dmem[DAddr[9:2]], DWData, DByteEn);
        end
    end

    task automatic checkWord(input string name, input isaPkg::wordT got,
                             input isaPkg::wordT exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            valueErrs++;
        end
    endtask

    task automatic checkByteEn(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAIL DByteEn: got %h, expected %h", got, exp);
            valueErrs++;
        end
    endtask

    // Stores are matched by order, not by cycle
    task automatic handleStore();
        if (storeIdx >= expAddr.size()) begin
            $display("Store to address %h came after the last expected store", DAddr);
            otherErrs++;
        end else begin
            checkWord("DAddr", DAddr, expAddr[storeIdx]);
            checkWord("DWData", DWData, expData[storeIdx]);
            checkByteEn(DByteEn, 4'hf);
            storeIdx++;
        end
    endtask

    task automatic loadTestdata(output bit ok);
        int nStores;
        int base;
        ok = 1'b0;
        for (int i = 0; i < TDATA_WORDS; i++) begin
            tdata[i] = 'x;
        end
        $readmemh("sim/cpu_testdata.hex", tdata);
        if ($isunknown(tdata[0])) begin
            $display("Testdata file could not be read");
            return;
        end
        progLen = tdata[0];
        nStores = tdata[progLen + 1];
        base    = progLen + 2;
        if (progLen > MEM_WORDS || base + 2 * nStores >= TDATA_WORDS) begin
            $display("Testdata file has counts that do not fit its contents");
            return;
        end
        for (int i = 0; i < progLen; i++) begin
            imem[i] = tdata[i + 1];
        end
        for (int i = 0; i < nStores; i++) begin
            expAddr.push_back(tdata[base + 2 * i]);
            expData.push_back(tdata[base + 2 * i + 1]);
        end
        finalPc = tdata[base + 2 * nStores];
        ok = !$isunknown(finalPc);
        if (!ok) begin
            $display("Testdata file ends before the final PC");
        end
    endtask

    initial begin
        bit loaded;
        int cycles;
        int limit;
        rstN      = 1'b0;
        storeIdx  = 0;
        valueErrs = 0;
        otherErrs = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        loadTestdata(loaded);
        if (!loaded) begin
            otherErrs++;
        end else begin
            limit = 4 * progLen + 50;
            repeat (4) @(posedge clk);
            #1 rstN = 1'b1;
            @(negedge clk);
            cycles = 1;
            checkWord("IAddr", IAddr, `CPU_RESET_PC);
            if (DWEn !== 1'b0 || DREn !== 1'b0) begin
                $display("Data port was active right after reset");
                otherErrs++;
            end
            while (storeIdx < expAddr.size() && cycles < limit) begin
                @(negedge clk);
                cycles++;
                if (DWEn) begin
                    handleStore();
                end
            end
            if (storeIdx < expAddr.size()) begin
                $display("Timeout: only %0d of %0d stores seen within %0d cycles",
                         storeIdx, expAddr.size(), limit);
                otherErrs++;
            end else begin
                // Core should now sit in its jump-to-self loop
                repeat (SETTLE_CYCLES) begin
                    @(negedge clk);
                    if (DWEn) begin
                        handleStore();
                    end
                end
                checkWord("PC", PC, finalPc);
            end
        end
        $display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/cpu_testdata.hex
// Program word count, then program words from the reset PC, then store count,
// then one expected store per line as address and data, then the final PC
0000002c
34011234 // 3000 ori   $1, $0, 0x1234
3c02abcd // 3004 lui   $2, 0xabcd
00221821 // 3008 addu  $3, $1, $2
ac030000 // 300c sw    $3, 0($0)
00612023 // 3010 subu  $4, $3, $1
2405fffd // 3014 addiu $5, $0, -3
00a1302a // 3018 slt   $6, $5, $1
00013900 // 301c sll   $7, $1, 4
00674024 // 3020 and   $8, $3, $7
00874825 // 3024 or    $9, $4, $7
ac010004 // 3028 sw    $1, 4($0)
ac020008 // 302c sw    $2, 8($0)
ac04000c // 3030 sw    $4, 12($0)
ac050010 // 3034 sw    $5, 16($0)
ac060014 // 3038 sw    $6, 20($0)
ac070018 // 303c sw    $7, 24($0)
ac08001c // 3040 sw    $8, 28($0)
ac090020 // 3044 sw    $9, 32($0)
8c0a0000 // 3048 lw    $10, 0($0)
254b0001 // 304c addiu $11, $10, 1
ac0b0024 // 3050 sw    $11, 36($0)
8c0c000c // 3054 lw    $12, 12($0)
ac0c0028 // 3058 sw    $12, 40($0)
10c00008 // 305c beq   $6, $0, 3080   not taken
240d0011 // 3060 addiu $13, $0, 0x11
15a60002 // 3064 bne   $13, $6, 3070  taken
ac0d002c // 3068 sw    $13, 44($0)    delay slot
ac06003c // 306c sw    $6, 60($0)     skipped
8c0f0010 // 3070 lw    $15, 16($0)
11e50002 // 3074 beq   $15, $5, 3080  taken
24100022 // 3078 addiu $16, $0, 0x22
ac10003c // 307c sw    $16, 60($0)    skipped
1400fffb // 3080 bne   $0, $0, 3070   not taken
ac100030 // 3084 sw    $16, 48($0)    delay slot
0c000c27 // 3088 jal   309c
00000000 // 308c nop
ac1f0034 // 3090 sw    $31, 52($0)
08000c2a // 3094 j     30a8
00000000 // 3098 nop
24110044 // 309c addiu $17, $0, 0x44
03e00008 // 30a0 jr    $31
ac110038 // 30a4 sw    $17, 56($0)    delay slot
08000c2a // 30a8 j     30a8
00000000 // 30ac nop
0000000f
00000000 abcd1234
00000004 00001234
00000008 abcd0000
0000000c abcd0000
00000010 fffffffd
00000014 00000001
00000018 00012340
0000001c 00010200
00000020 abcd2340
00000024 abcd1235
00000028 abcd0000
0000002c 00000011
00000030 00000022
00000038 00000044
00000034 00003090
000030ac
